//--- all.f
design/jpeg_stream_pkg.sv
design/frame_control.sv
design/bit_packer.sv
design/word_serializer.sv
design/byte_stuffer.sv
design/jpeg_stream_top.sv
verification/tb_jpeg_stream.sv

//--- design/bit_packer.sv
// bit packer: appends variable-length codewords MSB first and emits
// each completed 32-bit word

`timescale 1ns/1ns

module bit_packer (
    input  logic                          clock,
    input  logic                          nreset,
    input  logic                          clear_i,
    input  jpeg_stream_pkg::codeword_t    codeword_i,
    output jpeg_stream_pkg::packed_word_t word_o
);
    import jpeg_stream_pkg::*;

    // acc_q holds fill_q bits left-aligned, all bits below them are zero
    logic [code_width-1:0]   acc_q;
    logic [len_width-1:0]    fill_q;
    logic [6:0]              total;
    logic [6:0]              shift_amt;
    logic [2*code_width-1:0] code_ext;
    logic [2*code_width-1:0] window;
    logic                    word_ready;
    logic                    word_valid_q;
    logic [code_width-1:0]   word_data_q;

    assign total = {1'b0, fill_q} + {1'b0, codeword_i.length};
    assign shift_amt = 7'd64 - total;

    // only the low length bits of the codeword count
    assign code_ext = {{code_width{1'b0}}, codeword_i.bits} &
                      ~({(2*code_width){1'b1}} << codeword_i.length);

    // place the new bits directly after the ones already held
    assign window = {acc_q, {code_width{1'b0}}} | (code_ext << shift_amt);
    assign word_ready = codeword_i.valid && (total >= 7'd32);

    always_ff @(posedge clock) begin
        if (nreset) begin
            acc_q <= '0;
            fill_q <= '0;
            word_valid_q <= 1'b0;
        end else if (clear_i) begin
            acc_q <= '0;
            fill_q <= '0;
            word_valid_q <= 1'b0;
        end else begin
            word_valid_q <= word_ready;
            if (codeword_i.valid) begin
                if (word_ready) begin
                    // the remainder moves up to the top of the accumulator
                    acc_q <= window[code_width-1:0];
                    fill_q <= len_width'(total - 7'd32);
                end else begin
                    acc_q <= window[2*code_width-1:code_width];
                    fill_q <= len_width'(total);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_ready) begin
            word_data_q <= window[2*code_width-1:code_width];
        end
    end

    assign word_o = '{valid: word_valid_q, data: word_data_q};

    // upstream must never send more than a full word of bits at once
    a_length_in_range: assert property (@(posedge clock) disable iff (nreset)
        codeword_i.valid |-> (codeword_i.length <= len_width'(code_width)));

endmodule

//--- design/byte_stuffer.sv
// byte stuffer: forwards each byte and follows every ff with an inserted 00

`timescale 1ns/1ns

module byte_stuffer (
    input  logic                          clock,
    input  logic                          nreset,
    input  jpeg_stream_pkg::stream_byte_t byte_i,
    output jpeg_stream_pkg::stream_byte_t byte_o
);
    import jpeg_stream_pkg::*;

    logic                  pending_q;
    logic                  out_valid_q;
    logic [byte_width-1:0] out_data_q;

    always_ff @(posedge clock) begin
        if (nreset) begin
            pending_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else if (pending_q) begin
            // this cycle belongs to the stuffed zero
            pending_q <= 1'b0;
            out_valid_q <= 1'b1;
        end else begin
            out_valid_q <= byte_i.valid;
            pending_q <= byte_i.valid && (byte_i.data == {byte_width{1'b1}});
        end
    end

    always_ff @(posedge clock) begin
        if (pending_q) begin
            out_data_q <= '0;
        end else if (byte_i.valid) begin
            out_data_q <= byte_i.data;
        end
    end

    assign byte_o = '{valid: out_valid_q, data: out_data_q};

    // the serializer leaves a gap after every byte for the zero
    a_byte_while_pending: assert property (@(posedge clock) disable iff (nreset)
        byte_i.valid |-> !pending_q);

endmodule

//--- design/frame_control.sv
// frame control: vsync synchronizer, MCU counter, packer flush FSM
// and the frame-valid hold counter

`timescale 1ns/1ns

module frame_control (
    input  logic                       clock,
    input  logic                       nreset,
    input  jpeg_stream_pkg::codeword_t codeword_i,
    input  logic                       mcu_done_i,
    input  logic                       sensor_vsync_i,
    input  logic                       packed_valid_i,
    output jpeg_stream_pkg::codeword_t packer_codeword_o,
    output logic                       clear_packer_o,
    output logic                       frame_valid_o
);
    import jpeg_stream_pkg::*;

    logic [2:0]                  vsync_sync_q;
    logic                        vsync_rise;
    logic [mcu_count_width-1:0]  mcu_count_q;
    logic                        frame_done;
    flush_state_e                state_q;
    flush_state_e                state_d;
    logic [hold_count_width-1:0] hold_count_q;

    //////////////////////////////
    // vsync synchronizer and MCU count

    // first two stages resolve metastability, the third holds the previous level
    assign vsync_rise = vsync_sync_q[1] & ~vsync_sync_q[2];
    assign frame_done = (mcu_count_q >= mcus_per_frame);

    always_ff @(posedge clock) begin
        if (nreset) begin
            vsync_sync_q <= 3'b000;
            mcu_count_q <= '0;
        end else begin
            vsync_sync_q <= {vsync_sync_q[1:0], sensor_vsync_i};
            if (vsync_rise) begin
                mcu_count_q <= '0;
            end else if (mcu_done_i && !frame_done) begin
                mcu_count_q <= mcu_count_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // flush FSM

    always_comb begin
        state_d = state_q;
        packer_codeword_o = codeword_i;
        clear_packer_o = 1'b0;
        case (state_q)
            flush_idle: begin
                // codewords arriving after the last MCU belong to no frame
                packer_codeword_o.valid = codeword_i.valid & ~frame_done;
                if (frame_done) begin
                    state_d = flush_ones;
                end
            end
            flush_ones: begin
                // a full word of ones pushes out whatever the packer still holds
                packer_codeword_o.valid = 1'b1;
                packer_codeword_o.length = len_width'(code_width);
                packer_codeword_o.bits = '1;
                state_d = flush_clear;
            end
            flush_clear: begin
                packer_codeword_o = '0;
                clear_packer_o = 1'b1;
                if (!frame_done) begin
                    state_d = flush_idle;
                end
            end
            default: begin
                packer_codeword_o = '0;
                state_d = flush_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (nreset) begin
            state_q <= flush_idle;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // frame valid hold

    always_ff @(posedge clock) begin
        if (nreset) begin
            hold_count_q <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            if (!frame_done) begin
                hold_count_q <= '0;
            end else if (hold_count_q != pipeline_lifetime) begin
                hold_count_q <= hold_count_q + 1'b1;
            end
            if (packed_valid_i) begin
                frame_valid_o <= 1'b1;
            end else if (hold_count_q >= pipeline_lifetime) begin
                frame_valid_o <= 1'b0;
            end
        end
    end

endmodule

//--- design/jpeg_stream_pkg.sv
// shared widths, frame constants, flush state encoding and port structs
// for the JPEG output stream

package jpeg_stream_pkg;

    // codeword field and packed word width
    localparam int code_width = 32;
    // codeword length holds 0 to 32
    localparam int len_width = 6;
    localparam int byte_width = 8;

    ////////////////////////////////
    // frame constants
    localparam int mcu_count_width = 11;
    localparam logic [mcu_count_width-1:0] mcus_per_frame = 11'd1200;

    // upper bound on how long bits stay in the output chain after the last MCU
    localparam int hold_count_width = 16;
    localparam logic [hold_count_width-1:0] pipeline_lifetime = 16'd256;

    typedef enum logic [1:0] {
        flush_idle  = 2'b00,
        flush_ones  = 2'b01,
        flush_clear = 2'b10
    } flush_state_e;

    ////////////////////////////////
    // port structs
    typedef struct packed {
        logic                  valid;
        logic [len_width-1:0]  length;
        logic [code_width-1:0] bits;
    } codeword_t;

    typedef struct packed {
        logic                  valid;
        logic [code_width-1:0] data;
    } packed_word_t;

    typedef struct packed {
        logic                  valid;
        logic [byte_width-1:0] data;
    } stream_byte_t;

endpackage

//--- design/jpeg_stream_top.sv
// top level of the JPEG output stream: frame control, bit packer,
// word serializer and byte stuffer

`timescale 1ns/1ns

module jpeg_stream_top (
    input  logic                                  clock,
    input  logic                                  nreset,
    input  jpeg_stream_pkg::codeword_t            codeword_i,
    input  logic                                  mcu_done_i,
    input  logic                                  sensor_vsync_i,
    output logic                                  byte_valid_o,
    output logic [jpeg_stream_pkg::byte_width-1:0] byte_o,
    output logic                                  frame_valid_o
);
    import jpeg_stream_pkg::*;

    codeword_t    packer_codeword;
    logic         clear_packer;
    packed_word_t packed_word;
    stream_byte_t raw_byte;
    stream_byte_t stuffed_byte;

    //////////////////////////////
    // control
    frame_control frame_control_inst (
        .clock             (clock),
        .nreset            (nreset),
        .codeword_i        (codeword_i),
        .mcu_done_i        (mcu_done_i),
        .sensor_vsync_i    (sensor_vsync_i),
        .packed_valid_i    (packed_word.valid),
        .packer_codeword_o (packer_codeword),
        .clear_packer_o    (clear_packer),
        .frame_valid_o     (frame_valid_o)
    );

    //////////////////////////////
    // datapath
    bit_packer bit_packer_inst (
        .clock      (clock),
        .nreset     (nreset),
        .clear_i    (clear_packer),
        .codeword_i (packer_codeword),
        .word_o     (packed_word)
    );

    word_serializer word_serializer_inst (
        .clock  (clock),
        .nreset (nreset),
        .word_i (packed_word),
        .byte_o (raw_byte)
    );

    byte_stuffer byte_stuffer_inst (
        .clock  (clock),
        .nreset (nreset),
        .byte_i (raw_byte),
        .byte_o (stuffed_byte)
    );

    assign byte_valid_o = stuffed_byte.valid;
    assign byte_o = stuffed_byte.data;

endmodule

//--- design/word_serializer.sv
// word serializer: splits a 32-bit word into four bytes, most significant
// first, on every other cycle

`timescale 1ns/1ns

module word_serializer (
    input  logic                          clock,
    input  logic                          nreset,
    input  jpeg_stream_pkg::packed_word_t word_i,
    output jpeg_stream_pkg::stream_byte_t byte_o
);
    import jpeg_stream_pkg::*;

    // phase 0 is idle, 1 to 7 step through one word
    logic [2:0]            phase_q;
    logic                  emit;
    logic [code_width-1:0] shift_q;
    logic                  byte_valid_q;
    logic [byte_width-1:0] byte_data_q;

    // the remaining three bytes leave on the even phases
    assign emit = (phase_q != 3'd0) && !phase_q[0];

    always_ff @(posedge clock) begin
        if (nreset) begin
            phase_q <= 3'd0;
            byte_valid_q <= 1'b0;
        end else begin
            byte_valid_q <= word_i.valid || emit;
            if (word_i.valid) begin
                phase_q <= 3'd1;
            end else if (phase_q != 3'd0) begin
                phase_q <= phase_q + 3'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (word_i.valid) begin
            byte_data_q <= word_i.data[code_width-1 -: byte_width];
            shift_q <= {word_i.data[code_width-byte_width-1:0], {byte_width{1'b0}}};
        end else if (emit) begin
            byte_data_q <= shift_q[code_width-1 -: byte_width];
            shift_q <= {shift_q[code_width-byte_width-1:0], {byte_width{1'b0}}};
        end
    end

    assign byte_o = '{valid: byte_valid_q, data: byte_data_q};

    // the codeword spacing rule keeps packed words at least 8 cycles apart
    a_word_while_busy: assert property (@(posedge clock) disable iff (nreset)
        word_i.valid |-> (phase_q == 3'd0));

endmodule

//--- run_sim.sh
#!/bin/sh
# build the JPEG output stream testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_jpeg_stream -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_jpeg_stream > "$log_file" 2>&1
status=$?
cat "$log_file"

if grep -q "CHECKS FAILED" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

//--- verification/tb_jpeg_stream.sv
// testbench for the JPEG output stream with LFSR codeword stimulus, a bit-level
// reference model, a byte monitor and assertion checks

`timescale 1ns/1ns

module tb_jpeg_stream;
    import jpeg_stream_pkg::*;

    localparam int clock_period = 8;
    localparam int frame_mcus = int'(mcus_per_frame);
    // pipeline lifetime plus a margin for the flush word
    localparam int frame_valid_limit = 276;

    logic                  clock;
    logic                  nreset;
    codeword_t             codeword;
    logic                  mcu_done;
    logic                  sensor_vsync;
    logic                  byte_valid;
    logic [byte_width-1:0] stream_byte;
    logic                  frame_valid;

    // reference model state
    logic [31:0] lfsr_state;
    bit          exp_bits[$];
    int          model_fill;
    int          mcus_sent;
    int          done_cycle;
    int          cycle_count;
    int          ff_count;

    // monitor results that the assertions check on the following edge
    logic        check_q;
    logic        extra_q;
    logic        after_ff_q;
    logic [7:0]  exp_byte_q;
    logic [7:0]  got_byte_q;

    jpeg_stream_top jpeg_stream_top_inst (
        .clock          (clock),
        .nreset         (nreset),
        .codeword_i     (codeword),
        .mcu_done_i     (mcu_done),
        .sensor_vsync_i (sensor_vsync),
        .byte_valid_o   (byte_valid),
        .byte_o         (stream_byte),
        .frame_valid_o  (frame_valid)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    //////////////////////////////
    // stimulus helpers

    // taps of x^32 + x^22 + x^2 + x + 1 with the feedback entering at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // appends the low length bits with the MSB first
    task automatic push_bits(input logic [31:0] bits, input int length);
        logic [31:0] shifted;
        shifted = bits << (32 - length);
        for (int i = 0; i < length; i++) begin
            exp_bits.push_back(shifted[31]);
            shifted = shifted << 1;
        end
        model_fill = (model_fill + length) % 32;
    endtask

    task automatic send_codeword(input int length, input logic [31:0] bits);
        @(posedge clock);
        #1;
        codeword.valid = 1'b1;
        codeword.length = len_width'(length);
        codeword.bits = bits;
        // once the frame is complete the DUT drops codewords
        if (mcus_sent < frame_mcus) begin
            push_bits(bits, length);
        end
        @(posedge clock);
        #1;
        codeword = '0;
        repeat (8) @(posedge clock);
    endtask

    task automatic pulse_mcu();
        @(posedge clock);
        #1;
        mcu_done = 1'b1;
        @(posedge clock);
        #1;
        mcu_done = 1'b0;
        mcus_sent++;
        if (mcus_sent == frame_mcus) begin
            // flush pads the partial word with ones, or sends a whole word of ones
            if (model_fill != 0) begin
                push_bits(32'hffff_ffff, 32 - model_fill);
            end else begin
                push_bits(32'hffff_ffff, 32);
            end
            done_cycle = cycle_count;
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_bits.size() != 0 && waited < limit) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (exp_bits.size() != 0) begin
            fail_run($sformatf("output stream stopped with %0d expected bits left",
                               exp_bits.size()));
        end
    endtask

    task automatic wait_for_frame_end();
        while (frame_valid && (cycle_count - done_cycle) <= frame_valid_limit) begin
            @(posedge clock);
            #1;
        end
        if (frame_valid) begin
            fail_run("frame_valid_o stayed high too long after the frame completed");
        end
    endtask

    //////////////////////////////
    // output monitor

    // drops the zero after each ff and compares every data byte with the model
    always @(posedge clock) begin : byte_monitor
        logic [7:0] expected;
        check_q <= 1'b0;
        extra_q <= 1'b0;
        if (nreset) begin
            after_ff_q <= 1'b0;
        end else if (byte_valid) begin
            if (after_ff_q) begin
                after_ff_q <= 1'b0;
            end else if (exp_bits.size() < 8) begin
                extra_q <= 1'b1;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    expected = {expected[6:0], exp_bits.pop_front()};
                end
                exp_byte_q <= expected;
                got_byte_q <= stream_byte;
                check_q <= 1'b1;
                after_ff_q <= (stream_byte == 8'hff);
                if (stream_byte == 8'hff) begin
                    ff_count++;
                end
            end
        end
    end

    //////////////////////////////
    // checks

    a_quiet_in_reset: assert property (@(posedge clock)
        ($past(nreset) || $past(nreset, 2)) |-> (!byte_valid && !frame_valid))
        else fail_run($sformatf(
            "FAILED at %0t: byte_valid_o/frame_valid_o expected 0/0 got %0b/%0b",
            $time, $sampled(byte_valid), $sampled(frame_valid)));

    a_byte_matches: assert property (@(posedge clock) disable iff (nreset)
        check_q |-> (got_byte_q == exp_byte_q))
        else fail_run($sformatf("FAILED at %0t: byte_o expected %02h got %02h",
                                $time, $sampled(exp_byte_q), $sampled(got_byte_q)));

    a_zero_after_ff: assert property (@(posedge clock) disable iff (nreset)
        (byte_valid && after_ff_q) |-> (stream_byte == 8'h00))
        else fail_run($sformatf("FAILED at %0t: byte_o expected 00 got %02h",
                                $time, $sampled(stream_byte)));

    a_no_extra_byte: assert property (@(posedge clock) disable iff (nreset) !extra_q)
        else fail_run("a byte appeared on byte_o with no expected data left");

    a_valid_in_frame: assert property (@(posedge clock) disable iff (nreset)
        byte_valid |-> frame_valid)
        else fail_run($sformatf("FAILED at %0t: frame_valid_o expected 1 got %0b",
                                $time, $sampled(frame_valid)));

    //////////////////////////////
    // main sequence

    initial begin
        int          length;
        logic [31:0] bits;
        nreset = 1'b1;
        codeword = '0;
        mcu_done = 1'b0;
        sensor_vsync = 1'b0;
        lfsr_state = 32'hdda98ca6;
        model_fill = 0;
        mcus_sent = 0;
        done_cycle = 0;
        repeat (3) @(posedge clock);
        #1;
        nreset = 1'b0;
        repeat (4) @(posedge clock);

        // first frame uses random lengths and a stretch of all-ones codewords
        for (int mcu = 0; mcu < frame_mcus; mcu++) begin
            for (int n = 0; n < mcu % 3; n++) begin
                length = int'(take_bits(5)) + 1;
                if (mcu >= 300 && mcu < 400) begin
                    bits = 32'hffff_ffff;
                end else begin
                    bits = take_bits(length);
                end
                send_codeword(length, bits);
            end
            pulse_mcu();
        end
        wait_for_drain(100);

        // these arrive after the frame is complete
        for (int n = 0; n < 4; n++) begin
            send_codeword(32, take_bits(32));
        end
        wait_for_frame_end();

        @(posedge clock);
        #1;
        sensor_vsync = 1'b1;
        repeat (6) @(posedge clock);
        #1;
        sensor_vsync = 1'b0;
        mcus_sent = 0;
        repeat (6) @(posedge clock);

        // second frame ends on a word boundary, so the flush is a word of ones
        for (int n = 0; n < 40; n++) begin
            send_codeword(16, take_bits(16));
        end
        for (int mcu = 0; mcu < frame_mcus; mcu++) begin
            pulse_mcu();
        end
        wait_for_drain(100);
        wait_for_frame_end();
        repeat (4) @(posedge clock);

        if (ff_count == 0) begin
            fail_run("no ff byte reached the output, stuffing was never exercised");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
